//--- Makefile
TOP = cnn_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary -j 0 -Wno-fatal --top-module $(TOP) -f sources.f

# Pass only when the exact pass line shows up in the output
run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

lint:
	verilator --lint-only --timing --top-module cnn_top -f sources.f

clean:
	rm -rf obj_dir

//--- sim/cnn_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cnn_tb;

	localparam int          clk_period      = 4;
	localparam logic [31:0] seed            = 32'h0e19_031b;
	// Windows summed over the single, sequence, clamp and restart runs
	localparam int          total_windows   = 69;
	localparam int          watchdog_cycles = total_windows * 40 + 3000;

	logic                        clk;
	logic                        reset_b;
	logic                        run;
	logic                        busy;
	logic [cnn_pkg::addr_w-1:0]  input_read_address;
	logic [cnn_pkg::data_w-1:0]  input_read_data;
	logic [cnn_pkg::addr_w-1:0]  weights_read_address;
	logic [cnn_pkg::data_w-1:0]  weights_read_data;
	logic                        output_write_enable;
	logic [cnn_pkg::addr_w-1:0]  output_write_address;
	logic [cnn_pkg::data_w-1:0]  output_write_data;
	logic                        input_write_enable;
	logic [cnn_pkg::addr_w-1:0]  input_write_address;
	logic [cnn_pkg::data_w-1:0]  input_write_data;
	logic                        weights_write_enable;
	logic [cnn_pkg::addr_w-1:0]  weights_write_address;
	logic [cnn_pkg::data_w-1:0]  weights_write_data;

	logic [15:0] image [4096];
	int          image_len;
	int          kernel [9];
	logic [15:0] expected [$];
	logic [31:0] rng_state;
	string       test_name;
	int          write_base;
	int          high_base;
	int          zero_base;
	int          value_errors;
	int          other_errors;
	// Owned by the comparator
	int          write_total;
	int          high_limit_bytes;
	int          zero_bytes;
	int          compare_value_errors;
	int          compare_other_errors;

	cnn_top dut_i (
		.clk                       (clk),
		.reset_b                   (reset_b),
		.run                       (run),
		.busy                      (busy),
		.input_sram_read_address   (input_read_address),
		.input_sram_read_data      (input_read_data),
		.weights_sram_read_address (weights_read_address),
		.weights_sram_read_data    (weights_read_data),
		.output_sram_write_enable  (output_write_enable),
		.output_sram_write_address (output_write_address),
		.output_sram_write_data    (output_write_data)
	);

	sram_model input_sram_i (
		.clk           (clk),
		.read_address  (input_read_address),
		.read_data     (input_read_data),
		.write_enable  (input_write_enable),
		.write_address (input_write_address),
		.write_data    (input_write_data)
	);

	sram_model weights_sram_i (
		.clk           (clk),
		.read_address  (weights_read_address),
		.read_data     (weights_read_data),
		.write_enable  (weights_write_enable),
		.write_address (weights_write_address),
		.write_data    (weights_write_data)
	);

	sram_model output_sram_i (
		.clk           (clk),
		.read_address  ('0),
		.read_data     (),
		.write_enable  (output_write_enable),
		.write_address (output_write_address),
		.write_data    (output_write_data)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(clk_period / 2) clk = ~clk;
		end
	end

	// ------------------------------
	// Stimulus helpers
	// ------------------------------
	function automatic logic [7:0] random_byte();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state[31:24];
	endfunction

	function automatic void add_random_matrix(int n);
		logic [7:0] lo;
		image[image_len] = 16'(n);
		image_len++;
		for (int k = 0; k < n * n / 2; k++) begin
			lo = random_byte();
			image[image_len] = {random_byte(), lo};
			image_len++;
		end
	endfunction

	// Top half of the rows +100, bottom half -100
	function automatic void add_banded_matrix(int n);
		logic [7:0] p;
		image[image_len] = 16'(n);
		image_len++;
		for (int k = 0; k < n * n / 2; k++) begin
			p = (2 * k / n < n / 2) ? 8'h64 : 8'h9c;
			image[image_len] = {p, p};
			image_len++;
		end
	endfunction

	function automatic void add_end_marker();
		image[image_len] = 16'hffff;
		image_len++;
	endfunction

	function automatic void random_kernel();
		logic signed [7:0] w;
		for (int k = 0; k < 9; k++) begin
			w = random_byte();
			kernel[k] = w;
		end
	endfunction

	function automatic logic [7:0] kernel_byte(int k);
		return (k < 9) ? 8'(kernel[k]) : 8'h00;
	endfunction

	// ------------------------------
	// Reference model
	// ------------------------------
	function automatic int pixel_at(int base, int n, int r, int c);
		logic [15:0]       word;
		logic signed [7:0] p;
		word = image[base + 1 + (r * n + c) / 2];
		p = (c % 2 == 1) ? word[15:8] : word[7:0];
		return p;
	endfunction

	// Conv, 2x2 max pool, clamp, then pack pairs per matrix
	function automatic void compute_expected();
		int         base;
		int         n;
		int         count;
		int         acc;
		int         best;
		int         val;
		logic [7:0] held;
		expected.delete();
		base = 0;
		held = '0;
		while (image[base] != 16'hffff) begin
			n = int'(image[base]);
			count = 0;
			for (int a = 0; a < n / 2 - 1; a++) begin
				for (int b = 0; b < n / 2 - 1; b++) begin
					best = -(1 << 30);
					for (int d = 0; d < 4; d++) begin
						acc = 0;
						for (int k = 0; k < 9; k++) begin
							acc += kernel[k] * pixel_at(base, n,
								2 * a + d / 2 + k / 3, 2 * b + d % 2 + k % 3);
						end
						if (acc > best) begin
							best = acc;
						end
					end
					val = (best < 0) ? 0 : ((best > 127) ? 127 : best);
					if (count % 2 == 0) begin
						held = 8'(val);
					end else begin
						expected.push_back({held, 8'(val)});
					end
					count++;
				end
			end
			// Odd value left over at matrix end
			if (count % 2 == 1) begin
				expected.push_back({held, 8'h00});
			end
			base += 1 + n * n / 2;
		end
	endfunction

	task automatic load_memories();
		for (int a = 0; a < image_len; a++) begin
			@(posedge clk);
			input_write_enable  <= 1'b1;
			input_write_address <= 12'(a);
			input_write_data    <= image[a];
		end
		@(posedge clk);
		input_write_enable <= 1'b0;
		for (int k = 0; k < cnn_pkg::kernel_words; k++) begin
			@(posedge clk);
			weights_write_enable  <= 1'b1;
			weights_write_address <= 12'(k);
			weights_write_data    <= {kernel_byte(2 * k + 1), kernel_byte(2 * k)};
		end
		@(posedge clk);
		weights_write_enable <= 1'b0;
	endtask

	task automatic run_test(input string name, input int windows);
		int cycles;
		compute_expected();
		load_memories();
		test_name  = name;
		write_base = write_total;
		high_base  = high_limit_bytes;
		zero_base  = zero_bytes;
		@(posedge clk);
		run <= 1'b1;
		@(posedge clk);
		run <= 1'b0;
		@(negedge clk);
		if (busy !== 1'b1) begin
			value_errors++;
			$display("[FAIL] %s: busy after run expected 1, actual %b", name, busy);
		end
		cycles = 0;
		while (busy === 1'b1 && cycles < windows * 40 + 100) begin
			@(negedge clk);
			cycles++;
		end
		if (busy === 1'b1) begin
			other_errors++;
			$display("%s: busy never fell after the run", name);
		end
		// Quiet time to catch late writes
		repeat (4) @(posedge clk);
		if (write_total - write_base != expected.size()) begin
			other_errors++;
			$display("%s: saw %0d output writes where %0d were expected", name,
				write_total - write_base, expected.size());
		end
	endtask

	// ------------------------------
	// Comparator
	// ------------------------------
	always @(negedge clk) begin
		int idx;
		if (reset_b && output_write_enable) begin
			idx = write_total - write_base;
			if (idx >= expected.size()) begin
				compare_other_errors++;
				$display("%s: output write to %h beyond the expected words", test_name,
					output_write_address);
			end else begin
				if (output_write_address !== 12'(idx)) begin
					compare_value_errors++;
					$display("[FAIL] %s: address expected %h, actual %h", test_name,
						12'(idx), output_write_address);
				end
				if (output_write_data !== expected[idx]) begin
					compare_value_errors++;
					$display("[FAIL] %s: word %0d expected %h, actual %h", test_name, idx,
						expected[idx], output_write_data);
				end
			end
			if (busy !== 1'b1) begin
				compare_other_errors++;
				$display("%s: output write while busy was low", test_name);
			end
			if (output_write_data[15:8] == 8'd127) begin
				high_limit_bytes++;
			end
			if (output_write_data[15:8] == 8'd0) begin
				zero_bytes++;
			end
			write_total++;
		end
	end

	function automatic int error_total();
		return value_errors + other_errors + compare_value_errors + compare_other_errors;
	endfunction

	// ------------------------------
	// Test sequence
	// ------------------------------
	initial begin
		rng_state             = seed;
		reset_b               = 1'b0;
		run                   = 1'b0;
		input_write_enable    = 1'b0;
		input_write_address   = '0;
		input_write_data      = '0;
		weights_write_enable  = 1'b0;
		weights_write_address = '0;
		weights_write_data    = '0;
		image_len             = 0;
		value_errors          = 0;
		other_errors          = 0;
		write_base            = 0;
		test_name             = "reset_idle";
		repeat (3) @(posedge clk);
		reset_b <= 1'b1;

		// Nothing moves before run
		repeat (8) begin
			@(negedge clk);
			if (busy !== 1'b0) begin
				value_errors++;
				$display("[FAIL] reset_idle: busy expected 0, actual %b", busy);
			end
			if (output_write_enable !== 1'b0) begin
				value_errors++;
				$display("[FAIL] reset_idle: write enable expected 0, actual %b",
					output_write_enable);
			end
		end

		image_len = 0;
		add_random_matrix(4);
		add_end_marker();
		random_kernel();
		run_test("single_4x4", 1);

		image_len = 0;
		add_random_matrix(8);
		add_random_matrix(16);
		add_end_marker();
		random_kernel();
		run_test("seq_8_16", 58);

		// Flat kernel of 16 saturates both ways on the banded matrix
		image_len = 0;
		add_banded_matrix(8);
		add_end_marker();
		for (int k = 0; k < 9; k++) begin
			kernel[k] = 16;
		end
		run_test("clamp", 9);
		if (high_limit_bytes == high_base || zero_bytes == zero_base) begin
			other_errors++;
			$display("clamp: writes did not include both 127 and 0");
		end

		image_len = 0;
		add_random_matrix(4);
		add_end_marker();
		random_kernel();
		run_test("restart", 1);

		$display("errors: %0d value, %0d other", value_errors + compare_value_errors,
			other_errors + compare_other_errors);
		if (error_total() == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		#(watchdog_cycles * clk_period);
		$display("watchdog expired after %0d cycles", watchdog_cycles);
		$display("errors: %0d value, %0d other", value_errors + compare_value_errors,
			other_errors + compare_other_errors);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/sram_model.sv
`timescale 1ns/1ps
`default_nettype none

module sram_model (
	input  wire                          clk,
	input  wire  [cnn_pkg::addr_w-1:0]   read_address,
	output logic [cnn_pkg::data_w-1:0]   read_data,
	input  wire                          write_enable,
	input  wire  [cnn_pkg::addr_w-1:0]   write_address,
	input  wire  [cnn_pkg::data_w-1:0]   write_data
);

	logic [cnn_pkg::data_w-1:0] mem [2**cnn_pkg::addr_w];

	// Background pattern, unique per address
	initial begin
		for (int a = 0; a < 2**cnn_pkg::addr_w; a++) begin
			mem[a] = {4'hd, 12'(a)};
		end
	end

	// ------------------------------
	// One-cycle read, plain write
	// ------------------------------
	always_ff @(posedge clk) begin
		read_data <= mem[read_address];
	end

	always @(posedge clk) begin
		if (write_enable) begin
			mem[write_address] <= write_data;
		end
	end

endmodule

`default_nettype wire

//--- sources.f
verilog/cnn_pkg.sv
verilog/window_fetch.sv
verilog/conv_engine.sv
verilog/pool_relu_writer.sv
verilog/cnn_top.sv
sim/sram_model.sv
sim/cnn_tb.sv

//--- verilog/cnn_pkg.sv
`default_nettype none

package cnn_pkg;

	// ------------------------------
	// Bus and datapath widths
	// ------------------------------
	localparam int addr_w = 12;
	localparam int data_w = 16;
	localparam int pix_w  = 8;
	localparam int acc_w  = 20;
	localparam int dim_w  = 8;

	// Size word that terminates a run
	localparam logic [data_w-1:0] end_marker = 16'hffff;
	// Nine kernel bytes, high byte of the last word unused
	localparam int kernel_words = 5;
	localparam logic [pix_w-1:0] relu_max = 8'd127;
	// First write increments this to address 0
	localparam logic [addr_w-1:0] out_addr_start = 12'hfff;

	// ------------------------------
	// FSM encodings
	// ------------------------------
	localparam logic [2:0] fetch_idle        = 3'd0;
	localparam logic [2:0] fetch_read_size   = 3'd1;
	localparam logic [2:0] fetch_check_size  = 3'd2;
	localparam logic [2:0] fetch_read_window = 3'd3;
	localparam logic [2:0] fetch_check1      = 3'd4;
	localparam logic [2:0] fetch_check2      = 3'd5;
	localparam logic [2:0] fetch_done        = 3'd6;

	localparam logic [1:0] win_empty = 2'd0;
	localparam logic [1:0] win_fill  = 2'd1;
	localparam logic [1:0] win_mult  = 2'd2;

	// Input SRAM word, read either as a size or as two pixels
	typedef union packed {
		logic [data_w-1:0] size;
		struct packed {
			logic [pix_w-1:0] hi;
			logic [pix_w-1:0] lo;
		} pair;
	} sram_word_u;

endpackage

`default_nettype wire

//--- verilog/cnn_top.sv
`timescale 1ns/1ps
`default_nettype none

module cnn_top (
	input  wire                          clk,
	input  wire                          reset_b,
	input  wire                          run,
	output logic                         busy,
	output logic [cnn_pkg::addr_w-1:0]   input_sram_read_address,
	input  wire  [cnn_pkg::data_w-1:0]   input_sram_read_data,
	output logic [cnn_pkg::addr_w-1:0]   weights_sram_read_address,
	input  wire  [cnn_pkg::data_w-1:0]   weights_sram_read_data,
	output logic                         output_sram_write_enable,
	output logic [cnn_pkg::addr_w-1:0]   output_sram_write_address,
	output logic [cnn_pkg::data_w-1:0]   output_sram_write_data
);

	// Fetch to convolution
	logic size_valid;
	logic pixel_valid;
	logic window_start;
	logic matrix_last;
	logic buffer_empty;

	// Convolution to writer
	logic                              conv_valid;
	logic                              conv_matrix_done;
	logic signed [cnn_pkg::acc_w-1:0]  conv_0;
	logic signed [cnn_pkg::acc_w-1:0]  conv_1;
	logic signed [cnn_pkg::acc_w-1:0]  conv_2;
	logic signed [cnn_pkg::acc_w-1:0]  conv_3;
	logic                              output_done;

	window_fetch fetch_i (
		.clk                     (clk),
		.reset_b                 (reset_b),
		.run                     (run),
		.input_sram_read_data    (input_sram_read_data),
		.buffer_empty            (buffer_empty),
		.output_done             (output_done),
		.busy                    (busy),
		.input_sram_read_address (input_sram_read_address),
		.size_valid              (size_valid),
		.pixel_valid             (pixel_valid),
		.window_start            (window_start),
		.matrix_last             (matrix_last)
	);

	conv_engine conv_i (
		.clk                       (clk),
		.reset_b                   (reset_b),
		.input_sram_read_data      (input_sram_read_data),
		.size_valid                (size_valid),
		.pixel_valid               (pixel_valid),
		.window_start              (window_start),
		.matrix_last               (matrix_last),
		.weights_sram_read_data    (weights_sram_read_data),
		.buffer_empty              (buffer_empty),
		.weights_sram_read_address (weights_sram_read_address),
		.conv_valid                (conv_valid),
		.conv_matrix_done          (conv_matrix_done),
		.conv_0                    (conv_0),
		.conv_1                    (conv_1),
		.conv_2                    (conv_2),
		.conv_3                    (conv_3)
	);

	pool_relu_writer writer_i (
		.clk                       (clk),
		.reset_b                   (reset_b),
		.busy                      (busy),
		.conv_valid                (conv_valid),
		.conv_matrix_done          (conv_matrix_done),
		.conv_0                    (conv_0),
		.conv_1                    (conv_1),
		.conv_2                    (conv_2),
		.conv_3                    (conv_3),
		.output_sram_write_enable  (output_sram_write_enable),
		.output_sram_write_address (output_sram_write_address),
		.output_sram_write_data    (output_sram_write_data),
		.output_done               (output_done)
	);

endmodule

`default_nettype wire

//--- verilog/conv_engine.sv
`timescale 1ns/1ps
`default_nettype none

module conv_engine (
	input  wire                               clk,
	input  wire                               reset_b,
	input  wire cnn_pkg::sram_word_u          input_sram_read_data,
	input  wire                               size_valid,
	input  wire                               pixel_valid,
	input  wire                               window_start,
	input  wire                               matrix_last,
	input  wire  [cnn_pkg::data_w-1:0]        weights_sram_read_data,
	output logic                              buffer_empty,
	output logic [cnn_pkg::addr_w-1:0]        weights_sram_read_address,
	output logic                              conv_valid,
	output logic                              conv_matrix_done,
	output logic signed [cnn_pkg::acc_w-1:0]  conv_0,
	output logic signed [cnn_pkg::acc_w-1:0]  conv_1,
	output logic signed [cnn_pkg::acc_w-1:0]  conv_2,
	output logic signed [cnn_pkg::acc_w-1:0]  conv_3
);

	logic [1:0]                         state;
	logic [3:0]                         step;
	logic [3:0]                         step_next;
	logic                               push;
	logic                               last_tap;
	logic                               row_step;
	logic                               window_last;
	logic signed [cnn_pkg::pix_w-1:0]   win [16];
	logic signed [cnn_pkg::pix_w-1:0]   tap [4];
	logic signed [cnn_pkg::pix_w-1:0]   weight;
	logic signed [2*cnn_pkg::pix_w-1:0] mul [4];
	logic signed [cnn_pkg::acc_w-1:0]   prod [4];
	logic signed [cnn_pkg::acc_w-1:0]   acc [4];
	logic signed [cnn_pkg::acc_w-1:0]   result [4];

	// The size word shares the data bus and is never buffered
	assign push         = pixel_valid && !size_valid;
	assign buffer_empty = (state == cnn_pkg::win_empty);
	assign last_tap     = (step == 4'(2 * cnn_pkg::kernel_words - 2));
	// Taps 2 and 5 end a kernel row
	assign row_step     = (step == 4'd2) || (step == 4'd5);
	assign step_next    = step + 4'd1;

	// Weight word for the next tap, read one cycle ahead
	assign weights_sram_read_address = (state == cnn_pkg::win_mult)
		? {{(cnn_pkg::addr_w-3){1'b0}}, step_next[3:1]} : '0;

	// ------------------------------
	// Window FSM
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!reset_b) begin
			state <= cnn_pkg::win_empty;
			step  <= '0;
		end else begin
			case (state)
				cnn_pkg::win_empty: begin
					if (push && window_start) begin
						state <= cnn_pkg::win_fill;
						step  <= 4'd1;
					end
				end
				cnn_pkg::win_fill: begin
					if (push) begin
						if (step == 4'd7) begin
							state <= cnn_pkg::win_mult;
							step  <= '0;
						end else begin
							step <= step_next;
						end
					end
				end
				cnn_pkg::win_mult: begin
					if (last_tap) begin
						state <= cnn_pkg::win_empty;
						step  <= '0;
					end else begin
						step <= step_next;
					end
				end
				default: state <= cnn_pkg::win_empty;
			endcase
		end
	end

	// Buffer is row-major, win[4*r + c]
	always_ff @(posedge clk) begin
		if (push) begin
			for (int i = 0; i < 14; i++) begin
				win[i] <= win[i + 2];
			end
			win[14] <= input_sram_read_data.pair.lo;
			win[15] <= input_sram_read_data.pair.hi;
		end else if (state == cnn_pkg::win_mult) begin
			// Move the next tap into the four read positions
			if (row_step) begin
				for (int i = 0; i < 14; i++) begin
					win[i] <= win[i + 2];
				end
				win[14] <= '0;
				win[15] <= '0;
			end else begin
				for (int i = 0; i < 15; i++) begin
					win[i] <= win[i + 1];
				end
				win[15] <= '0;
			end
		end
	end

	// ------------------------------
	// Multiply and accumulate
	// ------------------------------
	// Outputs 0..3 are top-left, top-right, bottom-left, bottom-right
	always_comb begin
		tap[0] = win[0];
		tap[1] = win[1];
		tap[2] = win[4];
		tap[3] = win[5];
		weight = step[0] ? weights_sram_read_data[2*cnn_pkg::pix_w-1:cnn_pkg::pix_w]
			: weights_sram_read_data[cnn_pkg::pix_w-1:0];
		for (int j = 0; j < 4; j++) begin
			mul[j]  = weight * tap[j];
			prod[j] = {{(cnn_pkg::acc_w-2*cnn_pkg::pix_w){mul[j][2*cnn_pkg::pix_w-1]}}, mul[j]};
		end
	end

	always_ff @(posedge clk) begin
		for (int j = 0; j < 4; j++) begin
			if (state == cnn_pkg::win_empty) begin
				acc[j] <= '0;
			end else if (state == cnn_pkg::win_mult) begin
				acc[j] <= acc[j] + prod[j];
			end
			if (state == cnn_pkg::win_mult && last_tap) begin
				result[j] <= acc[j] + prod[j];
			end
		end
	end

	assign conv_0 = result[0];
	assign conv_1 = result[1];
	assign conv_2 = result[2];
	assign conv_3 = result[3];

	// Matrix end follows the marked window's results
	always_ff @(posedge clk) begin
		if (!reset_b) begin
			window_last      <= 1'b0;
			conv_valid       <= 1'b0;
			conv_matrix_done <= 1'b0;
		end else begin
			if (state == cnn_pkg::win_empty && push && window_start) begin
				window_last <= matrix_last;
			end
			conv_valid       <= (state == cnn_pkg::win_mult) && last_tap;
			conv_matrix_done <= conv_valid && window_last;
		end
	end

endmodule

`default_nettype wire

//--- verilog/pool_relu_writer.sv
`timescale 1ns/1ps
`default_nettype none

module pool_relu_writer (
	input  wire                               clk,
	input  wire                               reset_b,
	input  wire                               busy,
	input  wire                               conv_valid,
	input  wire                               conv_matrix_done,
	input  wire signed [cnn_pkg::acc_w-1:0]   conv_0,
	input  wire signed [cnn_pkg::acc_w-1:0]   conv_1,
	input  wire signed [cnn_pkg::acc_w-1:0]   conv_2,
	input  wire signed [cnn_pkg::acc_w-1:0]   conv_3,
	output logic                              output_sram_write_enable,
	output logic [cnn_pkg::addr_w-1:0]        output_sram_write_address,
	output logic [cnn_pkg::data_w-1:0]        output_sram_write_data,
	output logic                              output_done
);

	logic signed [cnn_pkg::acc_w-1:0] max_01;
	logic signed [cnn_pkg::acc_w-1:0] max_23;
	logic signed [cnn_pkg::acc_w-1:0] pool_max;
	logic [cnn_pkg::pix_w-1:0]        relu_val;
	logic [cnn_pkg::pix_w-1:0]        relu_q;
	logic [cnn_pkg::pix_w-1:0]        held;
	logic                             relu_valid;
	logic                             relu_done;
	logic                             pending;
	logic                             write_now;
	logic                             flush_seen;

	// ------------------------------
	// 2x2 max pool and ReLU clamp
	// ------------------------------
	always_comb begin
		max_01   = (conv_0 > conv_1) ? conv_0 : conv_1;
		max_23   = (conv_2 > conv_3) ? conv_2 : conv_3;
		pool_max = (max_01 > max_23) ? max_01 : max_23;
		if (pool_max[cnn_pkg::acc_w-1]) begin
			relu_val = '0;
		end else if (pool_max > $signed({{(cnn_pkg::acc_w-cnn_pkg::pix_w){1'b0}},
			cnn_pkg::relu_max})) begin
			relu_val = cnn_pkg::relu_max;
		end else begin
			relu_val = pool_max[cnn_pkg::pix_w-1:0];
		end
	end

	// A word goes out on the second value of a pair or on a pending flush
	assign write_now = pending && (relu_valid || relu_done);

	always_ff @(posedge clk) begin
		if (!reset_b) begin
			relu_valid                <= 1'b0;
			relu_done                 <= 1'b0;
			pending                   <= 1'b0;
			flush_seen                <= 1'b0;
			output_done               <= 1'b0;
			output_sram_write_enable  <= 1'b0;
			output_sram_write_address <= cnn_pkg::out_addr_start;
		end else begin
			relu_valid               <= conv_valid;
			relu_done                <= conv_matrix_done;
			flush_seen               <= relu_done;
			output_done              <= flush_seen;
			output_sram_write_enable <= write_now;
			if (relu_valid) begin
				pending <= !pending;
			end else if (relu_done) begin
				pending <= 1'b0;
			end
			// Addresses run on across matrices until the run ends
			if (!busy) begin
				output_sram_write_address <= cnn_pkg::out_addr_start;
			end else if (write_now) begin
				output_sram_write_address <= output_sram_write_address + 12'd1;
			end
		end
	end

	// Earlier value lands in the high byte
	always_ff @(posedge clk) begin
		if (conv_valid) begin
			relu_q <= relu_val;
		end
		if (relu_valid && !pending) begin
			held <= relu_q;
		end
		if (relu_valid && pending) begin
			output_sram_write_data <= {held, relu_q};
		end else if (relu_done && pending) begin
			output_sram_write_data <= {held, {cnn_pkg::pix_w{1'b0}}};
		end
	end

endmodule

`default_nettype wire

//--- verilog/window_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module window_fetch (
	input  wire                          clk,
	input  wire                          reset_b,
	input  wire                          run,
	input  wire cnn_pkg::sram_word_u     input_sram_read_data,
	input  wire                          buffer_empty,
	input  wire                          output_done,
	output logic                         busy,
	output logic [cnn_pkg::addr_w-1:0]   input_sram_read_address,
	output logic                         size_valid,
	output logic                         pixel_valid,
	output logic                         window_start,
	output logic                         matrix_last
);

	logic [2:0]                  state;
	logic [2:0]                  read_idx;
	logic                        reading;
	logic                        size_is_end;
	logic [cnn_pkg::dim_w-1:0]   size_n;
	logic [2:0]                  log2n;
	logic [cnn_pkg::dim_w-1:0]   row;
	logic [cnn_pkg::dim_w-1:0]   col;
	logic                        last_col;
	logic                        last_row;
	logic                        matrix_end;
	logic [cnn_pkg::addr_w-1:0]  base_addr;
	logic [cnn_pkg::addr_w-1:0]  pix_off;
	logic [cnn_pkg::addr_w-1:0]  win_addr;
	logic [cnn_pkg::addr_w-1:0]  row_off;
	logic [cnn_pkg::addr_w:0]    n_sq;
	logic [cnn_pkg::addr_w-1:0]  matrix_words;

	assign busy        = (state != cnn_pkg::fetch_idle);
	assign reading     = (state == cnn_pkg::fetch_read_window);
	assign size_is_end = (input_sram_read_data.size == cnn_pkg::end_marker);

	// Size decoder, sizes are powers of two from 4 to 64
	always_comb begin
		case (size_n)
			8'd8:    log2n = 3'd3;
			8'd16:   log2n = 3'd4;
			8'd32:   log2n = 3'd5;
			8'd64:   log2n = 3'd6;
			default: log2n = 3'd2;
		endcase
	end

	assign last_col = (col == size_n - 8'd4);
	assign last_row = (row == size_n - 8'd4);

	// ------------------------------
	// Address generation
	// ------------------------------
	// Word offset of the window corner is (row * N + col) / 2
	assign pix_off  = ({{(cnn_pkg::addr_w-cnn_pkg::dim_w){1'b0}}, row} << log2n)
		+ {{(cnn_pkg::addr_w-cnn_pkg::dim_w){1'b0}}, col};
	assign win_addr = base_addr + (pix_off >> 1) + 12'd1;
	// Each window row is N/2 words further on
	assign row_off  = ({{(cnn_pkg::addr_w-2){1'b0}}, read_idx[2:1]} << log2n) >> 1;

	// Pixel words of one matrix, N*N/2 (N=64 needs the extra bit)
	assign n_sq         = {{(cnn_pkg::addr_w+1-cnn_pkg::dim_w){1'b0}}, size_n} << log2n;
	assign matrix_words = n_sq[cnn_pkg::addr_w:1];

	always_comb begin
		if (reading) begin
			input_sram_read_address = win_addr + row_off
				+ {{(cnn_pkg::addr_w-1){1'b0}}, read_idx[0]};
		end else begin
			// Size word stays on the bus through the size check
			input_sram_read_address = base_addr;
		end
	end

	// ------------------------------
	// Control FSM
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!reset_b) begin
			state    <= cnn_pkg::fetch_idle;
			read_idx <= '0;
		end else begin
			case (state)
				cnn_pkg::fetch_idle: begin
					if (run) begin
						state <= cnn_pkg::fetch_read_size;
					end
				end
				cnn_pkg::fetch_read_size: begin
					state <= cnn_pkg::fetch_check_size;
				end
				cnn_pkg::fetch_check_size: begin
					if (size_is_end) begin
						state <= cnn_pkg::fetch_done;
					end else if (buffer_empty) begin
						state <= cnn_pkg::fetch_read_window;
					end
				end
				cnn_pkg::fetch_read_window: begin
					read_idx <= read_idx + 3'd1;
					if (read_idx == 3'd7) begin
						state <= cnn_pkg::fetch_check1;
					end
				end
				cnn_pkg::fetch_check1: begin
					state <= cnn_pkg::fetch_check2;
				end
				cnn_pkg::fetch_check2: begin
					if (matrix_end) begin
						state <= cnn_pkg::fetch_read_size;
					end else if (buffer_empty) begin
						state <= cnn_pkg::fetch_read_window;
					end
				end
				cnn_pkg::fetch_done: begin
					if (output_done) begin
						state <= cnn_pkg::fetch_idle;
					end
				end
				default: state <= cnn_pkg::fetch_idle;
			endcase
		end
	end

	// Window walk, stride 2 along columns then rows
	always_ff @(posedge clk) begin
		if (!reset_b || !busy) begin
			base_addr  <= '0;
			row        <= '0;
			col        <= '0;
			matrix_end <= 1'b0;
		end else if (reading && read_idx == 3'd7) begin
			matrix_end <= last_col && last_row;
			if (!last_col) begin
				col <= col + 8'd2;
			end else begin
				col <= '0;
				if (last_row) begin
					row       <= '0;
					base_addr <= base_addr + matrix_words + 12'd1;
				end else begin
					row <= row + 8'd2;
				end
			end
		end
	end

	// Strobes line up with the read data
	always_ff @(posedge clk) begin
		if (!reset_b) begin
			size_valid   <= 1'b0;
			pixel_valid  <= 1'b0;
			window_start <= 1'b0;
			matrix_last  <= 1'b0;
		end else begin
			size_valid   <= (state == cnn_pkg::fetch_read_size);
			pixel_valid  <= reading;
			window_start <= reading && (read_idx == 3'd0);
			matrix_last  <= reading && (read_idx == 3'd0) && last_col && last_row;
		end
	end

	always_ff @(posedge clk) begin
		if (size_valid) begin
			size_n <= input_sram_read_data.size[cnn_pkg::dim_w-1:0];
		end
	end

endmodule

`default_nettype wire
